// File: build.f
obj_pkg.sv
obj_ram.sv
obj_scan.sv
obj_draw.sv
obj_linebuf.sv
obj_video.sv
tb_obj_model.sv
tb_obj_video.sv

// File: Bender.yml
package:
  name: obj_video

sources:
  - obj_pkg.sv
  - obj_ram.sv
  - obj_scan.sv
  - obj_draw.sv
  - obj_linebuf.sv
  - obj_video.sv
  - target: test
    files:
      - tb_obj_model.sv
      - tb_obj_video.sv

// File: tb_obj_video.sv
module tb_obj_video;
    timeunit 1ns;
    timeprecision 100ps;

    import obj_pkg::*;

    localparam int         MAX_OBJ    = DEF_MAX_OBJ;
    localparam logic [7:0] HOFFSET    = DEF_HOFFSET;
    localparam int         CLK_NS     = 8;
    // 384 pixels at one pixel every 2 clocks
    localparam int         LINE_CLK   = 768;
    localparam int         NUM_LINES  = 32;
    localparam int         FIRST_LINE = 40;
    localparam int         LIMIT_NS   = NUM_LINES * LINE_CLK * CLK_NS * 2;

    logic        clk;
    logic        rst;
    logic [9:0]  cpu_addr;
    logic [7:0]  cpu_din;
    logic        cpu_we;
    logic        frame;
    logic [7:0]  cpu_dout;
    logic        hinit;
    logic        lhbl;
    logic [8:0]  vdump;
    logic [8:0]  hdump;
    logic        flip;
    logic        pxl_cen;
    logic [7:0]  hpos;
    logic        scroll_we;
    logic [7:0]  prog_addr;
    logic [3:0]  prog_data;
    logic        prog_en;
    logic [13:0] rom_addr;
    logic        rom_cs;
    logic [31:0] rom_data;
    logic        rom_ok;
    logic [3:0]  pxl;

    int          errors = 0;
    int          max_lat = 6;
    int unsigned seed = 90;
    // Graphics ROM request tracking
    logic        pend = 1'b0;
    logic        served = 1'b0;
    logic [13:0] pend_addr = '0;
    int          wait_cnt = 0;

    obj_video #(.MAX_OBJ(MAX_OBJ), .HOFFSET(HOFFSET)) i_dut (.*);

    tb_obj_model #(.MAX_OBJ(MAX_OBJ), .HOFFSET(HOFFSET)) i_model ();

    always #(CLK_NS / 2) clk = ~clk;

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // ROM with a random 1 to max_lat cycle latency per address
    always @(posedge clk) begin
        #1;
        if (rom_cs && pend && rom_addr == pend_addr) begin
            if (wait_cnt > 0) begin
                wait_cnt--;
            end
        end else begin
            if (pend && !served) begin
                $display("rom request withdrawn before the ROM returned data at %0t", $time);
                errors++;
            end
            pend      = rom_cs;
            served    = 1'b0;
            pend_addr = rom_addr;
            wait_cnt  = 1 + $urandom % max_lat;
        end
        rom_ok = pend && wait_cnt == 0;
        if (rom_ok) begin
            served = 1'b1;
        end
        // Junk data while the ROM is not ready
        rom_data = rom_ok ? i_model.rom_word(pend_addr) : $urandom;
    end

    task automatic cpu_write(input logic f, input logic [9:0] a, input logic [7:0] d);
        frame    = f;
        cpu_addr = a;
        cpu_din  = d;
        cpu_we   = 1'b1;
        @(posedge clk);
        #1;
        cpu_we = 1'b0;
        i_model.put_byte(f, a, d);
    endtask

    task automatic cpu_check(input logic f, input logic [9:0] a);
        frame    = f;
        cpu_addr = a;
        @(posedge clk);
        #1;
        compare("cpu_dout", cpu_dout, i_model.get_byte(f, a));
    endtask

    // About a quarter of the PROM entries are transparent
    task automatic load_prom();
        logic [3:0] d;
        for (int a = 0; a < 256; a++) begin
            d         = ($urandom % 4 == 0) ? 4'd0 : 4'($urandom);
            prog_addr = 8'(a);
            prog_data = d;
            prog_en   = 1'b1;
            @(posedge clk);
            #1;
            i_model.set_prom(8'(a), d);
        end
        prog_en = 1'b0;
    endtask

    task automatic fill_tables();
        logic [7:0] top;
        for (int f = 0; f < 2; f++) begin
            for (int a = 0; a < 1024; a++) begin
                cpu_write(1'(f), 10'(a), 8'($urandom));
            end
            // Even entries sit near the plain lines, odd ones near the flipped lines
            for (int k = 0; k < MAX_OBJ; k++) begin
                top = (k % 2 == 1) ? 8'(168 + $urandom % 49) : 8'(24 + $urandom % 49);
                cpu_write(1'(f), 10'(4 * k + 1), ~top);
            end
        end
        // Table 0 read back after all of table 1 was written
        for (int f = 0; f < 2; f++) begin
            for (int a = 0; a < 1024; a++) begin
                cpu_check(1'(f), 10'(a));
            end
        end
    endtask

    // One raster line, frame toggles every 4 lines and flip every 8
    task automatic run_line(input int n);
        logic [8:0] v;
        logic [7:0] exp_scroll;
        int         scroll_cnt;
        v          = 9'(FIRST_LINE + n);
        frame      = n[2];
        flip       = n[3];
        vdump      = v;
        max_lat    = (n >= 16) ? 12 : 6;
        scroll_cnt = 0;
        i_model.next_line(!frame, v, flip);
        exp_scroll = i_model.scroll_of(!frame, v, flip);
        for (int c = 0; c < LINE_CLK; c++) begin
            hinit   = c == 0;
            hdump   = 9'(c / 2);
            pxl_cen = c % 2;
            lhbl    = c < 512;
            @(posedge clk);
            #1;
            if (scroll_we) begin
                scroll_cnt++;
                compare("hpos", hpos, exp_scroll);
            end
            // Both banks hold only drawn data from the third line on
            if (n >= 2 && pxl_cen && lhbl) begin
                compare($sformatf("pxl v=%0d x=%0d", v, hdump), pxl, i_model.shown[hdump[7:0]]);
            end
        end
        compare("scroll_we count", scroll_cnt, 1);
    endtask

    initial begin
        void'($urandom(seed));
        clk       = 1'b0;
        rst       = 1'b1;
        cpu_addr  = '0;
        cpu_din   = '0;
        cpu_we    = 1'b0;
        frame     = 1'b0;
        hinit     = 1'b0;
        lhbl      = 1'b0;
        vdump     = '0;
        hdump     = '0;
        flip      = 1'b0;
        pxl_cen   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        prog_en   = 1'b0;
        rom_data  = '0;
        rom_ok    = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        compare("scroll_we", scroll_we, 0);
        compare("rom_cs", rom_cs, 0);
        compare("pxl", pxl, 0);
        load_prom();
        fill_tables();
        for (int n = 0; n < NUM_LINES; n++) begin
            run_line(n);
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // Twice the time of all tested lines
    initial begin
        #(LIMIT_NS);
        $display("timeout: line scan never completed");
        $display("errors: %0d", errors);
        $display("Test FAILED");
        $finish;
    end

endmodule

// File: tb_obj_model.sv
module tb_obj_model #(
    parameter int         MAX_OBJ = obj_pkg::DEF_MAX_OBJ,
    parameter logic [7:0] HOFFSET = obj_pkg::DEF_HOFFSET
) ();
    timeunit 1ns;
    timeprecision 100ps;

    import obj_pkg::*;

    // Row scroll words start at 0x80 in the scanned table
    localparam logic [9:0] SCROLL_BASE = 10'h080;

    // Shadow copies of both object tables and of the palette PROM
    logic [7:0] shadow [0:1][0:1023];
    logic [3:0] prom [0:255];
    // Line being drawn and line on display
    logic [3:0] drawn [0:255];
    logic [3:0] shown [0:255];

    initial begin
        for (int x = 0; x < 256; x++) begin
            drawn[x] = 4'd0;
            shown[x] = 4'd0;
        end
    end

    task automatic put_byte(input logic t, input logic [9:0] a, input logic [7:0] d);
        shadow[t][a] = d;
    endtask

    function automatic logic [7:0] get_byte(input logic t, input logic [9:0] a);
        return shadow[t][a];
    endfunction

    task automatic set_prom(input logic [7:0] a, input logic [3:0] d);
        prom[a] = d;
    endtask

    // Graphics ROM contents, 8 pixels per word
    function automatic logic [31:0] rom_word(input logic [13:0] a);
        logic [31:0] h;
        h = {18'd0, a} * 32'h2545_f491;
        h = h ^ {a, a, 4'h9} ^ (h >> 15);
        return h;
    endfunction

    // hpos from the two scroll bytes of the row group
    function automatic logic [7:0] scroll_of(input logic t, input logic [8:0] v, input logic fl);
        logic [7:0] vf;
        logic [9:0] a;
        vf = v[7:0] ^ {8{fl}};
        a  = SCROLL_BASE + {vf[7:3], 1'b0};
        return {shadow[t][a + 10'd1][0], shadow[t][a][7:1]};
    endfunction

    // Shift the drawn line to display, then compose the line after v
    task automatic next_line(input logic t, input logic [8:0] v, input logic fl);
        obj_entry_t e;
        logic [7:0] ln;
        logic [7:0] top;
        logic [7:0] d;
        logic [3:0] row;
        logic [3:0] nib;
        logic [3:0] c;
        logic       hsel;
        int         p;
        for (int x = 0; x < 256; x++) begin
            shown[x] = drawn[x];
            drawn[x] = 4'd0;
        end
        ln = (v[7:0] + 8'd1) ^ {8{fl}};
        // High index first, so lower indices end on top
        for (int k = MAX_OBJ - 1; k >= 0; k--) begin
            e = {shadow[t][4 * k], shadow[t][4 * k + 1], shadow[t][4 * k + 2],
                 shadow[t][4 * k + 3]};
            top = ~e.ypos;
            d   = ln - top;
            if (d < 8'd16) begin
                row = e.attr[7] ? 4'd15 - d[3:0] : d[3:0];
                for (int i = 0; i < 16; i++) begin
                    // Mirrored sprites take the far ROM half first
                    hsel = (i >= 8) ^ e.attr[6];
                    p    = e.attr[6] ? 7 - i % 8 : i % 8;
                    nib  = 4'(rom_word({e.attr[5], e.code, row, hsel}) >> (4 * p));
                    c    = prom[{e.attr[3:0], nib}];
                    if (c != 4'd0) begin
                        drawn[(e.xpos + i + HOFFSET) % 256] = c;
                    end
                end
            end
        end
    endtask

endmodule

// File: obj_video.sv
module obj_video #(
    parameter int         MAX_OBJ = obj_pkg::DEF_MAX_OBJ,
    parameter logic [7:0] HOFFSET = obj_pkg::DEF_HOFFSET
) (
    input  logic        clk,
    input  logic        rst,
    // CPU interface
    input  logic [9:0]  cpu_addr,
    input  logic [7:0]  cpu_din,
    input  logic        cpu_we,
    input  logic        frame,
    output logic [7:0]  cpu_dout,
    // Video timing
    input  logic        hinit,
    input  logic        lhbl,
    input  logic [8:0]  vdump,
    input  logic [8:0]  hdump,
    input  logic        flip,
    input  logic        pxl_cen,
    // Row scroll
    output logic [7:0]  hpos,
    output logic        scroll_we,
    // Palette PROM load
    input  logic [7:0]  prog_addr,
    input  logic [3:0]  prog_data,
    input  logic        prog_en,
    // Graphics ROM
    output logic [13:0] rom_addr,
    output logic        rom_cs,
    input  logic [31:0] rom_data,
    input  logic        rom_ok,
    output logic [3:0]  pxl
);

    import obj_pkg::*;

    logic [9:0] scan_addr;
    logic [7:0] scan_data;
    draw_req_t  req;
    logic       draw;
    logic       busy;
    pix_wr_t    wr;

    // Object tables, CPU view and scan view
    obj_ram i_ram (
        .clk, .rst, .cpu_addr, .cpu_din, .cpu_we, .frame, .cpu_dout,
        .scan_addr, .scan_data
    );

    // Table walk and row scroll
    obj_scan #(.MAX_OBJ(MAX_OBJ)) i_scan (
        .clk, .rst, .hinit, .vdump, .flip, .scan_addr, .scan_data,
        .hpos, .scroll_we, .req, .draw, .busy
    );

    // ROM fetch and palette lookup
    obj_draw #(.HOFFSET(HOFFSET)) i_draw (
        .clk, .rst, .req, .draw, .busy, .rom_addr, .rom_cs, .rom_data,
        .rom_ok, .prog_addr, .prog_data, .prog_en, .wr
    );

    obj_linebuf i_linebuf (
        .clk, .rst, .hinit, .lhbl, .pxl_cen, .hdump, .wr, .pxl
    );

endmodule

// File: obj_linebuf.sv
module obj_linebuf (
    input  logic              clk,
    input  logic              rst,
    // Video timing
    input  logic              hinit,
    input  logic              lhbl,
    input  logic              pxl_cen,
    input  logic [8:0]        hdump,
    // Drawer writes
    input  obj_pkg::pix_wr_t  wr,
    output logic [3:0]        pxl
);

    // Bank that receives the drawer writes
    logic       sel;
    logic [3:0] rd [0:1];

    // Halves swap at each line start
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel <= 1'b0;
        end else if (hinit) begin
            sel <= ~sel;
        end
    end

    for (genvar b = 0; b < 2; b++) begin : g_bank
        logic [3:0] mem [0:255];
        logic       draw_side;

        assign draw_side = sel == 1'(b);

        // Draw side takes pixel writes
        // Display side is cleared as it is shown
        always_ff @(posedge clk) begin
            if (draw_side) begin
                if (wr.we) begin
                    mem[wr.addr] <= wr.color;
                end
            end else if (pxl_cen && lhbl) begin
                mem[hdump[7:0]] <= 4'd0;
            end
        end

        assign rd[b] = mem[hdump[7:0]];
    end

    // Output one clock after hdump, on the pixel enable
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pxl <= 4'd0;
        end else if (pxl_cen) begin
            pxl <= sel ? rd[0] : rd[1];
        end
    end

endmodule

// File: obj_draw.sv
module obj_draw #(
    parameter logic [7:0] HOFFSET = obj_pkg::DEF_HOFFSET
) (
    input  logic                clk,
    input  logic                rst,
    // Scanner
    input  obj_pkg::draw_req_t  req,
    input  logic                draw,
    output logic                busy,
    // Graphics ROM
    output logic [13:0]         rom_addr,
    output logic                rom_cs,
    input  logic [31:0]         rom_data,
    input  logic                rom_ok,
    // Palette PROM load
    input  logic [7:0]          prog_addr,
    input  logic [3:0]          prog_data,
    input  logic                prog_en,
    // Line buffer
    output obj_pkg::pix_wr_t    wr
);

    import obj_pkg::*;

    draw_state_e st;
    draw_req_t   r;
    logic [3:0]  prom [0:255];
    logic [31:0] pix;
    logic [3:0]  cnt;
    logic [13:0] iss_addr;
    logic [3:0]  yrow;
    logic [2:0]  px;
    logic [3:0]  nib;
    logic [3:0]  pal_px;

    // Palette PROM, loaded by the host
    always_ff @(posedge clk) begin
        if (prog_en) begin
            prom[prog_addr] <= prog_data;
        end
    end

    // Vertical flip reads the row from the bottom
    assign yrow = r.vflip ? ~r.ysub : r.ysub;

    // cnt[3] is the screen half, hflip swaps which ROM half it uses
    assign rom_addr = {r.code, yrow, cnt[3] ^ r.hflip};
    assign rom_cs   = st == DR_FETCH;

    // Pixel order inside a half is reversed by hflip
    assign px     = cnt[2:0] ^ {3{r.hflip}};
    assign nib    = pix[{px, 2'b00} +: 4];
    assign pal_px = prom[{r.pal, nib}];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st       <= DR_IDLE;
            busy     <= 1'b0;
            cnt      <= 4'd0;
            r        <= '0;
            pix      <= 32'd0;
            iss_addr <= 14'd0;
            wr       <= '0;
        end else begin
            // Address seen by the ROM on the previous cycle
            iss_addr <= rom_addr;
            wr.we    <= 1'b0;
            case (st)
                DR_IDLE: begin
                    if (draw) begin
                        r    <= req;
                        busy <= 1'b1;
                        cnt  <= 4'd0;
                        st   <= DR_FETCH;
                    end
                end
                DR_FETCH: begin
                    // rom_ok only counts once the ROM has seen this address
                    if (rom_cs && rom_ok && rom_addr == iss_addr) begin
                        pix <= rom_data;
                        st  <= DR_PLOT;
                    end
                end
                DR_PLOT: begin
                    wr.addr  <= r.xpos + {4'd0, cnt} + HOFFSET;
                    wr.color <= pal_px;
                    // Colour 0 is transparent
                    wr.we    <= pal_px != 4'd0;
                    cnt      <= cnt + 4'd1;
                    if (cnt[2:0] == 3'd7) begin
                        if (cnt[3]) begin
                            busy <= 1'b0;
                            st   <= DR_IDLE;
                        end else begin
                            // Second half of the row
                            st <= DR_FETCH;
                        end
                    end
                end
                default: st <= DR_IDLE;
            endcase
        end
    end

endmodule

// File: obj_scan.sv
module obj_scan #(
    parameter int MAX_OBJ = obj_pkg::DEF_MAX_OBJ
) (
    input  logic                clk,
    input  logic                rst,
    // Video timing
    input  logic                hinit,
    input  logic [8:0]          vdump,
    input  logic                flip,
    // Object table scan port
    output logic [9:0]          scan_addr,
    input  logic [7:0]          scan_data,
    // Row scroll
    output logic [7:0]          hpos,
    output logic                scroll_we,
    // Drawer
    output obj_pkg::draw_req_t  req,
    output logic                draw,
    input  logic                busy
);

    import obj_pkg::*;

    // First entry visited on each line
    localparam logic [7:0] LAST_IDX = 8'(MAX_OBJ - 1);

    scan_state_e st;
    obj_entry_t  ent;
    logic        cen2;
    logic        hinit_x;
    logic [3:0]  ysub;
    logic        in_zone;
    logic [7:0]  vdf;
    logic [7:0]  line_nx;
    logic [7:0]  ydiff;

    // Scroll rows follow the current line, sprites the next one
    assign vdf     = vdump[7:0] ^ {8{flip}};
    assign line_nx = (vdump[7:0] + 8'd1) ^ {8{flip}};
    // Distance from the sprite top, ypos holds the inverted top line
    assign ydiff   = line_nx - ~ent.ypos;

    // Half rate step enable
    // hinit is held until the next step sees it
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cen2    <= 1'b0;
            hinit_x <= 1'b0;
        end else begin
            cen2 <= ~cen2;
            if (hinit) begin
                hinit_x <= 1'b1;
            end else if (cen2) begin
                hinit_x <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st        <= SC_IDLE;
            scan_addr <= 10'd0;
            hpos      <= 8'd0;
            scroll_we <= 1'b0;
            draw      <= 1'b0;
            ent       <= '0;
            ysub      <= 4'd0;
            in_zone   <= 1'b0;
        end else begin
            // Strobes last a single clock
            scroll_we <= 1'b0;
            draw      <= 1'b0;
            if (cen2) begin
                case (st)
                    SC_IDLE: begin
                        if (hinit_x) begin
                            // Row scroll word at 0x80 + 2*(v/8)
                            scan_addr <= 10'h080 + {4'd0, vdf[7:3], 1'b0};
                            st        <= SC_SCROLL_LO;
                        end
                    end
                    SC_SCROLL_LO: begin
                        hpos[6:0]    <= scan_data[7:1];
                        scan_addr[0] <= 1'b1;
                        st           <= SC_SCROLL_HI;
                    end
                    SC_SCROLL_HI: begin
                        // Only bit 0 of the upper byte matters
                        hpos[7]   <= scan_data[0];
                        scroll_we <= 1'b1;
                        scan_addr <= {LAST_IDX, 2'b00};
                        st        <= SC_ATTR;
                    end
                    SC_ATTR: begin
                        ent.attr       <= scan_data;
                        scan_addr[1:0] <= 2'd1;
                        st             <= SC_YPOS;
                    end
                    SC_YPOS: begin
                        ent.ypos       <= scan_data;
                        scan_addr[1:0] <= 2'd2;
                        st             <= SC_CODE;
                    end
                    SC_CODE: begin
                        ent.code       <= scan_data;
                        // In zone when the next line is within 16 rows of the top
                        in_zone        <= ydiff[7:4] == 4'd0;
                        ysub           <= ydiff[3:0];
                        scan_addr[1:0] <= 2'd3;
                        st             <= SC_XPOS;
                    end
                    SC_XPOS: begin
                        // Hold here while the previous sprite is still drawn
                        if (!in_zone || !busy) begin
                            ent.xpos  <= scan_data;
                            draw      <= in_zone;
                            scan_addr <= {scan_addr[9:2] - 8'd1, 2'b00};
                            st        <= SC_WAIT;
                        end
                    end
                    SC_WAIT: begin
                        // busy rises during this step
                        // Index wrapped past 0 means the table is done
                        st <= (scan_addr[9:2] == 8'hff) ? SC_IDLE : SC_ATTR;
                    end
                    default: st <= SC_IDLE;
                endcase
            end
        end
    end

    // Request fields straight from the latched entry
    always_comb begin
        req.code  = {ent.attr[5], ent.code};
        req.xpos  = ent.xpos;
        req.pal   = ent.attr[3:0];
        req.hflip = ent.attr[6];
        req.vflip = ent.attr[7];
        req.ysub  = ysub;
    end

endmodule

// File: obj_ram.sv
module obj_ram (
    input  logic       clk,
    input  logic       rst,
    // CPU side
    input  logic [9:0] cpu_addr,
    input  logic [7:0] cpu_din,
    input  logic       cpu_we,
    input  logic       frame,
    output logic [7:0] cpu_dout,
    // Scanner side
    input  logic [9:0] scan_addr,
    output logic [7:0] scan_data
);

    // Two 1 kB object tables
    logic [7:0] tbl0 [0:1023];
    logic [7:0] tbl1 [0:1023];

    // CPU writes land in the table that frame points at
    always_ff @(posedge clk) begin
        if (cpu_we && !frame) begin
            tbl0[cpu_addr] <= cpu_din;
        end
        if (cpu_we && frame) begin
            tbl1[cpu_addr] <= cpu_din;
        end
    end

    // CPU readback is combinational
    assign cpu_dout = frame ? tbl1[cpu_addr] : tbl0[cpu_addr];

    // Scan port reads the other table
    // One cycle of read latency
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scan_data <= 8'd0;
        end else begin
            scan_data <= frame ? tbl0[scan_addr] : tbl1[scan_addr];
        end
    end

endmodule

// File: obj_pkg.sv
package obj_pkg;

    // One sprite entry, four bytes in table order
    typedef struct packed {
        // Bit 7 vflip, bit 6 hflip, bit 5 code msb, bits 3..0 palette
        logic [7:0] attr;
        // Stored inverted
        logic [7:0] ypos;
        logic [7:0] code;
        logic [7:0] xpos;
    } obj_entry_t;

    // Scanner to drawer request
    typedef struct packed {
        logic [8:0] code;
        logic [7:0] xpos;
        logic [3:0] pal;
        logic       hflip;
        logic       vflip;
        // Row inside the 16-line sprite
        logic [3:0] ysub;
    } draw_req_t;

    // Drawer to line buffer pixel write
    typedef struct packed {
        logic [7:0] addr;
        logic [3:0] color;
        logic       we;
    } pix_wr_t;

    typedef enum logic [2:0] {
        SC_IDLE, SC_SCROLL_LO, SC_SCROLL_HI, SC_ATTR,
        SC_YPOS, SC_CODE, SC_XPOS, SC_WAIT
    } scan_state_e;

    typedef enum logic [1:0] {
        DR_IDLE, DR_FETCH, DR_PLOT
    } draw_state_e;

    // Entries walked per raster line
    localparam int DEF_MAX_OBJ = 24;
    // Horizontal pixel offset of the line buffer writes
    localparam logic [7:0] DEF_HOFFSET = 8'd6;

endpackage
